// ==== project.f ====
+incdir+hw
hw/bypass_pkg.sv
hw/reg_hazard_unit.sv
hw/csr_hazard_unit.sv
hw/stall_fwd_combine.sv
hw/bypass_ctrl.sv
dv/bypass_ctrl_sva.sv
dv/bypass_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: bypass_ctrl

export_include_dirs:
  - hw

sources:
  - files:
      - hw/bypass_pkg.sv
      - hw/reg_hazard_unit.sv
      - hw/csr_hazard_unit.sv
      - hw/stall_fwd_combine.sv
      - hw/bypass_ctrl.sv
  - target: test
    files:
      - dv/bypass_ctrl_sva.sv
      - dv/bypass_ctrl_tb.sv

// ==== dv/bypass_ctrl_tb.sv ====
// The DUT is combinational, so the clock only paces stimulus; random vectors rely on the bound checker
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl_tb;

  localparam bypass_pkg::op_fw_sel_e   sel_rf  = bypass_pkg::SEL_REGFILE;
  localparam bypass_pkg::op_fw_sel_e   sel_ex  = bypass_pkg::SEL_FW_EX;
  localparam bypass_pkg::op_fw_sel_e   sel_wb  = bypass_pkg::SEL_FW_WB;
  localparam bypass_pkg::jalr_fw_sel_e selj_rf = bypass_pkg::SELJ_REGFILE;
  localparam bypass_pkg::jalr_fw_sel_e selj_wb = bypass_pkg::SELJ_FW_WB;
  localparam int max_cycles    = 2000;
  localparam int rand_per_test = 24;

  logic clk   = 1'b0;
  logic rst_i = 1'b1;

  // DUT inputs
  bypass_pkg::rd_port_vec_t rf_re_id_i;
  bypass_pkg::rf_addr_t     rf_raddr_a_id_i, rf_raddr_b_id_i, ex_rf_waddr_i, wb_rf_waddr_i;
  bypass_pkg::csr_addr_t    ex_csr_raddr_i, wb_csr_waddr_i;
  logic id_valid_i, id_mret_i, id_tbljmp_i, jalr_id_i;
  logic ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i, ex_csr_impl_wr_i;
  logic ex_wfi_i, ex_csr_impl_re_i, ex_csr_expl_re_i;
  logic wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_ready_i, wb_csr_en_i, wb_mret_i;
  logic wb_csr_impl_wr_i, wb_csr_expl_we_i;

  // DUT outputs
  bypass_pkg::op_fw_sel_e   op_a_fw_sel_o, op_b_fw_sel_o;
  bypass_pkg::jalr_fw_sel_e jalr_fw_sel_o;
  logic load_stall_o, jalr_stall_o, csr_stall_id_o, csr_stall_ex_o;
  logic sleep_stall_o, id_stall_o, ex_stall_o;

  logic [11:0] outs;
  logic [31:0] lfsr = 32'hb35775fe;
  string       cur_test;
  int          test_errs;
  int          sva_base;
  int          vec_errs = 0;
  int          tests    = 0;
  int          total;

  always #50 clk = ~clk;

  bypass_ctrl u_dut (.*);

  bind bypass_ctrl bypass_ctrl_sva u_sva (
    .clk_i (bypass_ctrl_tb.clk),
    .rst_i (bypass_ctrl_tb.rst_i),
    .*
  );

  // All outputs in one word, selects first and the stage summaries last
  assign outs = {op_a_fw_sel_o, op_b_fw_sel_o, jalr_fw_sel_o, load_stall_o, jalr_stall_o,
                 csr_stall_id_o, csr_stall_ex_o, sleep_stall_o, id_stall_o, ex_stall_o};

  // Reset is held over two rising edges and released just after the second
  initial begin
    for (int n = 0; n < 2; n++) @(posedge clk);
    #1 rst_i = 1'b0;
  end

  // Overall run limit
  initial begin
    for (int cyc = 0; cyc < max_cycles; cyc++) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // ID stalls on any of its causes, EX only on its own CSR hazard
  function automatic logic [11:0] exp_out(
    input bypass_pkg::op_fw_sel_e a, input bypass_pkg::op_fw_sel_e b,
    input bypass_pkg::jalr_fw_sel_e j, input logic load, input logic jalr,
    input logic cid, input logic cex, input logic slp);
    return {a, b, j, load, jalr, cid, cex, slp, load | jalr | cid | slp, cex};
  endfunction

  task automatic clear_inputs();
    rf_re_id_i      = '0;
    rf_raddr_a_id_i = '0;
    rf_raddr_b_id_i = '0;
    ex_rf_waddr_i   = '0;
    wb_rf_waddr_i   = '0;
    ex_csr_raddr_i  = '0;
    wb_csr_waddr_i  = '0;
    {id_valid_i, id_mret_i, id_tbljmp_i, jalr_id_i} = '0;
    {ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i, ex_csr_impl_wr_i} = '0;
    {ex_wfi_i, ex_csr_impl_re_i, ex_csr_expl_re_i} = '0;
    {wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_csr_en_i, wb_mret_i} = '0;
    {wb_csr_impl_wr_i, wb_csr_expl_we_i} = '0;
    // Memory has answered unless a test says otherwise
    wb_ready_i = 1'b1;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_i && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (rst_i) begin
      $display("reset was still high after 10 cycles");
      $display("Simulation FAILED");
      $finish;
    end
    #1;
  endtask

  // Outputs settled right after the last drive, so the next edge is a safe sample point
  task automatic check(input logic [11:0] exp);
    @(posedge clk);
    if (outs !== exp) begin
      $display("mismatch %s: expected %03h actual %03h", cur_test, exp, outs);
      test_errs++;
      vec_errs++;
    end
    #1;
  endtask

  // Tiny address ranges so that random reads and writes collide often
  task automatic apply_random(input int count);
    for (int n = 0; n < count; n++) begin
      rf_re_id_i      = 2'(rand_bits(2));
      rf_raddr_a_id_i = 5'(rand_bits(2));
      rf_raddr_b_id_i = 5'(rand_bits(2));
      ex_rf_waddr_i   = 5'(rand_bits(2));
      wb_rf_waddr_i   = 5'(rand_bits(2));
      ex_csr_raddr_i  = 12'h300 | 12'(rand_bits(2));
      wb_csr_waddr_i  = 12'h300 | 12'(rand_bits(2));
      {id_valid_i, id_mret_i, id_tbljmp_i, jalr_id_i} = 4'(rand_bits(4));
      {ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i} = 5'(rand_bits(5));
      {ex_csr_impl_wr_i, ex_wfi_i, ex_csr_impl_re_i, ex_csr_expl_re_i} = 4'(rand_bits(4));
      {wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_ready_i, wb_csr_en_i} = 5'(rand_bits(5));
      {wb_mret_i, wb_csr_impl_wr_i, wb_csr_expl_we_i} = 3'(rand_bits(3));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
    sva_base  = int'(u_dut.u_sva.err_cnt);
    clear_inputs();
  endtask

  task automatic end_test();
    apply_random(rand_per_test);
    tests++;
    $display("test %s: %0d vector errors, %0d assertion errors", cur_test, test_errs,
             int'(u_dut.u_sva.err_cnt) - sva_base);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_fwd_priority();
    begin_test("fwd_priority");
    rf_re_id_i = 2'b11;
    rf_raddr_a_id_i = 5'd5;
    rf_raddr_b_id_i = 5'd5;
    {ex_valid_i, ex_rf_we_i, ex_rf_waddr_i} = {2'b11, 5'd5};
    {wb_valid_i, wb_rf_we_i, wb_rf_waddr_i} = {2'b11, 5'd5};
    check(exp_out(sel_ex, sel_ex, selj_wb, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    ex_rf_waddr_i = 5'd6;
    check(exp_out(sel_wb, sel_wb, selj_wb, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    // Port a reads x0 and port b is not enabled
    rf_re_id_i = 2'b01;
    rf_raddr_a_id_i = 5'd0;
    wb_rf_waddr_i = 5'd0;
    ex_rf_waddr_i = 5'd5;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_load_use();
    begin_test("load_use");
    rf_re_id_i = 2'b11;
    rf_raddr_a_id_i = 5'd3;
    rf_raddr_b_id_i = 5'd7;
    {ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_rf_waddr_i} = {3'b111, 5'd7};
    check(exp_out(sel_rf, sel_ex, selj_rf, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    ex_valid_i = 1'b0;
    {wb_valid_i, wb_rf_we_i, wb_rf_waddr_i} = {2'b11, 5'd3};
    check(exp_out(sel_wb, sel_rf, selj_wb, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    wb_ready_i = 1'b0;
    check(exp_out(sel_wb, sel_rf, selj_wb, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_jalr_path();
    begin_test("jalr_path");
    {id_valid_i, jalr_id_i} = 2'b11;
    rf_re_id_i = 2'b01;
    rf_raddr_a_id_i = 5'd9;
    {ex_valid_i, ex_rf_we_i, ex_rf_waddr_i} = {2'b11, 5'd9};
    check(exp_out(sel_ex, sel_rf, selj_rf, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    ex_valid_i = 1'b0;
    {wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_rf_waddr_i} = {3'b111, 5'd9};
    check(exp_out(sel_wb, sel_rf, selj_wb, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    wb_lsu_en_i = 1'b0;
    check(exp_out(sel_wb, sel_rf, selj_wb, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_csr_id();
    begin_test("csr_id");
    {id_valid_i, id_mret_i, ex_valid_i, ex_csr_en_i} = 4'b1111;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    {ex_csr_en_i, ex_mret_i} = 2'b01;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    // Table jump against an mret that has reached WB
    {ex_valid_i, ex_mret_i, wb_valid_i, wb_mret_i} = 4'b0011;
    {id_mret_i, id_tbljmp_i} = 2'b01;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    wb_mret_i = 1'b0;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    {wb_csr_en_i, id_valid_i} = 2'b10;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_csr_ex();
    begin_test("csr_ex");
    {ex_valid_i, ex_csr_en_i, ex_csr_expl_re_i} = 3'b111;
    {wb_valid_i, wb_csr_en_i, wb_csr_expl_we_i} = 3'b111;
    ex_csr_raddr_i = 12'h300;
    wb_csr_waddr_i = 12'h300;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    wb_csr_waddr_i = 12'h341;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    wb_csr_impl_wr_i = 1'b1;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    // Implicit read in EX against a plain CSR write in WB
    {ex_csr_en_i, ex_csr_expl_re_i, ex_csr_impl_re_i, wb_csr_impl_wr_i} = 4'b0010;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    end_test();
  endtask

  task automatic test_sleep_idle();
    begin_test("sleep_idle");
    {ex_valid_i, ex_wfi_i} = 2'b11;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    // Every qualifier busy but no stage valid
    ex_valid_i = 1'b0;
    rf_re_id_i = 2'b11;
    {rf_raddr_a_id_i, rf_raddr_b_id_i, ex_rf_waddr_i, wb_rf_waddr_i} = {4{5'd4}};
    {ex_rf_we_i, wb_rf_we_i, ex_lsu_en_i, wb_ready_i, jalr_id_i} = 5'b11101;
    {id_mret_i, ex_csr_en_i, wb_csr_en_i, wb_mret_i, ex_csr_impl_re_i} = 5'b11111;
    check(exp_out(sel_rf, sel_rf, selj_rf, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  initial begin
    clear_inputs();
    wait_reset_release();
    test_fwd_priority();
    test_load_use();
    test_jalr_path();
    test_csr_id();
    test_csr_ex();
    test_sleep_idle();
    total = vec_errs + int'(u_dut.u_sva.err_cnt);
    $display("tests=%0d vector_errors=%0d assertion_errors=%0d", tests, vec_errs,
             int'(u_dut.u_sva.err_cnt));
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/bypass_ctrl_sva.sv ====
// Bound into bypass_ctrl; clock and reset come from the testbench top since the DUT has neither
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl_sva (
  input logic                      clk_i,
  input logic                      rst_i,
  input bypass_pkg::rd_port_vec_t  rf_re_id_i,
  input bypass_pkg::rf_addr_t      rf_raddr_a_id_i, rf_raddr_b_id_i,
  input bypass_pkg::rf_addr_t      ex_rf_waddr_i, wb_rf_waddr_i,
  input bypass_pkg::csr_addr_t     ex_csr_raddr_i, wb_csr_waddr_i,
  input logic                      id_valid_i, id_mret_i, id_tbljmp_i, jalr_id_i,
  input logic                      ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i,
  input logic                      ex_mret_i, ex_wfi_i,
  input logic                      ex_csr_impl_re_i, ex_csr_expl_re_i,
  input logic                      wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_ready_i,
  input logic                      wb_csr_en_i, wb_mret_i, wb_csr_impl_wr_i, wb_csr_expl_we_i,
  input bypass_pkg::op_fw_sel_e    op_a_fw_sel_o, op_b_fw_sel_o,
  input bypass_pkg::jalr_fw_sel_e  jalr_fw_sel_o,
  input logic                      load_stall_o, jalr_stall_o, csr_stall_id_o,
  input logic                      csr_stall_ex_o, sleep_stall_o, id_stall_o, ex_stall_o
);

  // Failed checks, summed up by the testbench at the end of the run
  int unsigned err_cnt = 0;

  logic [1:0] hit_ex;
  logic [1:0] hit_wb;
  logic       rs1_ex;
  logic       rs1_wb;
  logic       ex_csr_wr;
  logic       wb_csr_wr;
  logic       wb_impl_wr;
  logic       any_valid;
  logic       exp_load;
  logic       exp_jalr;
  logic       exp_csr_id;
  logic       exp_csr_ex;
  logic       exp_sleep;

  // A read depends on a writer for an enabled port, a register other than x0 and a valid writer
  function automatic logic reads_from(input logic re, input bypass_pkg::rf_addr_t raddr,
                                      input logic valid, input logic we,
                                      input bypass_pkg::rf_addr_t waddr);
    return re && (raddr != '0) && valid && we && (raddr == waddr);
  endfunction

  // The youngest producer wins
  function automatic bypass_pkg::op_fw_sel_e pick_sel(input logic ex, input logic wb);
    return ex ? bypass_pkg::SEL_FW_EX : (wb ? bypass_pkg::SEL_FW_WB : bypass_pkg::SEL_REGFILE);
  endfunction

  assign hit_ex[0] = reads_from(rf_re_id_i[0], rf_raddr_a_id_i,
                                ex_valid_i, ex_rf_we_i, ex_rf_waddr_i);
  assign hit_ex[1] = reads_from(rf_re_id_i[1], rf_raddr_b_id_i,
                                ex_valid_i, ex_rf_we_i, ex_rf_waddr_i);
  assign hit_wb[0] = reads_from(rf_re_id_i[0], rf_raddr_a_id_i,
                                wb_valid_i, wb_rf_we_i, wb_rf_waddr_i);
  assign hit_wb[1] = reads_from(rf_re_id_i[1], rf_raddr_b_id_i,
                                wb_valid_i, wb_rf_we_i, wb_rf_waddr_i);

  // JALR reads rs1 whatever the port enable says
  assign rs1_ex = reads_from(1'b1, rf_raddr_a_id_i, ex_valid_i, ex_rf_we_i, ex_rf_waddr_i);
  assign rs1_wb = reads_from(1'b1, rf_raddr_a_id_i, wb_valid_i, wb_rf_we_i, wb_rf_waddr_i);

  // Every CSR instruction and every mret counts as a CSR writer
  assign ex_csr_wr  = ex_valid_i && (ex_csr_en_i || ex_mret_i);
  assign wb_csr_wr  = wb_valid_i && (wb_csr_en_i || wb_mret_i);
  assign wb_impl_wr = wb_valid_i && (wb_mret_i || (wb_csr_en_i && wb_csr_impl_wr_i));
  assign any_valid  = id_valid_i || ex_valid_i || wb_valid_i;

  // Stall levels built from the stage inputs alone
  assign exp_load   = (ex_lsu_en_i && (|hit_ex)) || (!wb_ready_i && (|hit_wb));
  assign exp_jalr   = jalr_id_i && (rs1_ex || (rs1_wb && wb_lsu_en_i));
  assign exp_csr_id = id_valid_i && (id_mret_i || id_tbljmp_i) && (ex_csr_wr || wb_csr_wr);
  assign exp_csr_ex = ex_valid_i && ((ex_csr_impl_re_i && wb_csr_wr) ||
                                     (ex_csr_en_i && wb_impl_wr) ||
                                     (ex_csr_expl_re_i && wb_valid_i && wb_csr_expl_we_i &&
                                      ex_csr_raddr_i == wb_csr_waddr_i));
  assign exp_sleep  = ex_valid_i && ex_wfi_i;

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////

  a_op_sel: assert property (@(posedge clk_i) disable iff (rst_i)
    op_a_fw_sel_o == pick_sel(hit_ex[0], hit_wb[0]) &&
    op_b_fw_sel_o == pick_sel(hit_ex[1], hit_wb[1]))
    else begin err_cnt++; $error("operand forward select differs from the priority rule"); end

  a_jalr: assert property (@(posedge clk_i) disable iff (rst_i)
    jalr_stall_o == exp_jalr &&
    jalr_fw_sel_o == (rs1_wb ? bypass_pkg::SELJ_FW_WB : bypass_pkg::SELJ_REGFILE))
    else begin err_cnt++; $error("JALR stall or JALR select is wrong"); end

  ////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////

  a_load: assert property (@(posedge clk_i) disable iff (rst_i)
    load_stall_o == exp_load)
    else begin err_cnt++; $error("load-use stall is wrong"); end

  a_csr_id: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_stall_id_o == exp_csr_id)
    else begin err_cnt++; $error("CSR stall in ID is wrong"); end

  a_csr_ex: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_stall_ex_o == exp_csr_ex)
    else begin err_cnt++; $error("CSR stall in EX is wrong"); end

  a_summary: assert property (@(posedge clk_i) disable iff (rst_i)
    sleep_stall_o == exp_sleep && ex_stall_o == exp_csr_ex &&
    id_stall_o == (exp_load || exp_jalr || exp_csr_id || exp_sleep))
    else begin err_cnt++; $error("sleep stall or stage stall summary is wrong"); end

  // With no valid instruction anywhere nothing may stall or forward
  a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !any_valid |-> !(load_stall_o || jalr_stall_o || csr_stall_id_o || csr_stall_ex_o ||
                     sleep_stall_o || id_stall_o || ex_stall_o) &&
                   op_a_fw_sel_o == bypass_pkg::SEL_REGFILE &&
                   op_b_fw_sel_o == bypass_pkg::SEL_REGFILE &&
                   jalr_fw_sel_o == bypass_pkg::SELJ_REGFILE)
    else begin err_cnt++; $error("idle pipeline still stalls or forwards"); end

endmodule

`default_nettype wire

// ==== hw/bypass_ctrl.sv ====
// Combinational hazard and bypass control for an ID/EX/WB pipeline; no clock, no reset, zero latency
`timescale 1ns/1ps
`default_nettype none

`include "bypass_macros.svh"

module bypass_ctrl (
  // ID stage
  input  bypass_pkg::rd_port_vec_t rf_re_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_a_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_b_id_i,
  input  logic                     id_valid_i,
  input  logic                     id_mret_i,
  input  logic                     id_tbljmp_i,
  input  logic                     jalr_id_i,

  // EX stage
  input  logic                     ex_valid_i,
  input  logic                     ex_rf_we_i,
  input  bypass_pkg::rf_addr_t     ex_rf_waddr_i,
  input  logic                     ex_lsu_en_i,
  input  logic                     ex_csr_en_i,
  input  logic                     ex_mret_i,
  input  logic                     ex_csr_impl_wr_i,
  input  logic                     ex_wfi_i,
  input  logic                     ex_csr_impl_re_i,
  input  logic                     ex_csr_expl_re_i,
  input  bypass_pkg::csr_addr_t    ex_csr_raddr_i,

  // WB stage
  input  logic                     wb_valid_i,
  input  logic                     wb_rf_we_i,
  input  bypass_pkg::rf_addr_t     wb_rf_waddr_i,
  input  logic                     wb_lsu_en_i,
  input  logic                     wb_ready_i,
  input  logic                     wb_csr_en_i,
  input  logic                     wb_mret_i,
  input  logic                     wb_csr_impl_wr_i,
  input  logic                     wb_csr_expl_we_i,
  input  bypass_pkg::csr_addr_t    wb_csr_waddr_i,

  // Forward selects and stalls
  output bypass_pkg::op_fw_sel_e   op_a_fw_sel_o,
  output bypass_pkg::op_fw_sel_e   op_b_fw_sel_o,
  output bypass_pkg::jalr_fw_sel_e jalr_fw_sel_o,
  output logic                     load_stall_o,
  output logic                     jalr_stall_o,
  output logic                     csr_stall_id_o,
  output logic                     csr_stall_ex_o,
  output logic                     sleep_stall_o,
  output logic                     id_stall_o,
  output logic                     ex_stall_o
);

  bypass_pkg::rd_port_vec_t ex_match;
  bypass_pkg::rd_port_vec_t wb_match;
  logic                     ex_jalr_match;
  logic                     wb_jalr_match;
  logic                     csr_stall_id;
  logic                     csr_stall_ex;
  logic                     sleep_stall;

  ////////////////////////////////////////////////////////////
  // Register and CSR hazard detection, side by side
  ////////////////////////////////////////////////////////////

  reg_hazard_unit u_reg_hz (
    .rf_re_id_i      (rf_re_id_i),
    .rf_raddr_a_id_i (rf_raddr_a_id_i),
    .rf_raddr_b_id_i (rf_raddr_b_id_i),
    .ex_valid_i      (ex_valid_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .wb_valid_i      (wb_valid_i),
    .wb_rf_we_i      (wb_rf_we_i),
    .wb_rf_waddr_i   (wb_rf_waddr_i),
    .ex_match_o      (ex_match),
    .wb_match_o      (wb_match),
    .ex_jalr_match_o (ex_jalr_match),
    .wb_jalr_match_o (wb_jalr_match)
  );

  csr_hazard_unit u_csr_hz (
    .id_valid_i       (id_valid_i),
    .id_mret_i        (id_mret_i),
    .id_tbljmp_i      (id_tbljmp_i),
    .ex_valid_i       (ex_valid_i),
    .ex_csr_en_i      (ex_csr_en_i),
    .ex_mret_i        (ex_mret_i),
    .ex_csr_impl_wr_i (ex_csr_impl_wr_i),
    .ex_wfi_i         (ex_wfi_i),
    .ex_csr_impl_re_i (ex_csr_impl_re_i),
    .ex_csr_expl_re_i (ex_csr_expl_re_i),
    .ex_csr_raddr_i   (ex_csr_raddr_i),
    .wb_valid_i       (wb_valid_i),
    .wb_csr_en_i      (wb_csr_en_i),
    .wb_mret_i        (wb_mret_i),
    .wb_csr_impl_wr_i (wb_csr_impl_wr_i),
    .wb_csr_expl_we_i (wb_csr_expl_we_i),
    .wb_csr_waddr_i   (wb_csr_waddr_i),
    .csr_stall_id_o   (csr_stall_id),
    .csr_stall_ex_o   (csr_stall_ex),
    .sleep_stall_o    (sleep_stall)
  );

  // Load, WB ready and JALR flags only matter once the matches are known
  stall_fwd_combine u_combine (
    .ex_match_i      (ex_match),
    .wb_match_i      (wb_match),
    .ex_jalr_match_i (ex_jalr_match),
    .wb_jalr_match_i (wb_jalr_match),
    .ex_lsu_en_i     (ex_lsu_en_i),
    .wb_lsu_en_i     (wb_lsu_en_i),
    .wb_ready_i      (wb_ready_i),
    .jalr_id_i       (jalr_id_i),
    .csr_stall_id_i  (csr_stall_id),
    .csr_stall_ex_i  (csr_stall_ex),
    .sleep_stall_i   (sleep_stall),
    .op_a_fw_sel_o   (op_a_fw_sel_o),
    .op_b_fw_sel_o   (op_b_fw_sel_o),
    .jalr_fw_sel_o   (jalr_fw_sel_o),
    .load_stall_o    (load_stall_o),
    .jalr_stall_o    (jalr_stall_o),
    .csr_stall_id_o  (csr_stall_id_o),
    .csr_stall_ex_o  (csr_stall_ex_o),
    .sleep_stall_o   (sleep_stall_o),
    .id_stall_o      (id_stall_o),
    .ex_stall_o      (ex_stall_o)
  );

endmodule

`default_nettype wire

// ==== hw/stall_fwd_combine.sv ====
// Purely combinational; match inputs must already carry writer valid, jalr_id_i must carry ID valid
`timescale 1ns/1ps
`default_nettype none

`include "bypass_macros.svh"

module stall_fwd_combine (
  input  bypass_pkg::rd_port_vec_t ex_match_i,
  input  bypass_pkg::rd_port_vec_t wb_match_i,
  input  logic                     ex_jalr_match_i,
  input  logic                     wb_jalr_match_i,
  input  logic                     ex_lsu_en_i,
  input  logic                     wb_lsu_en_i,
  input  logic                     wb_ready_i,
  input  logic                     jalr_id_i,
  input  logic                     csr_stall_id_i,
  input  logic                     csr_stall_ex_i,
  input  logic                     sleep_stall_i,

  output bypass_pkg::op_fw_sel_e   op_a_fw_sel_o,
  output bypass_pkg::op_fw_sel_e   op_b_fw_sel_o,
  output bypass_pkg::jalr_fw_sel_e jalr_fw_sel_o,
  output logic                     load_stall_o,
  output logic                     jalr_stall_o,
  output logic                     csr_stall_id_o,
  output logic                     csr_stall_ex_o,
  output logic                     sleep_stall_o,
  output logic                     id_stall_o,
  output logic                     ex_stall_o
);

  bypass_pkg::op_fw_sel_e op_sel [`BYP_NUM_RD_PORTS];

  ////////////////////////////////////////////////////////////
  // Forward selects
  ////////////////////////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < `BYP_NUM_RD_PORTS; i++) begin : gen_op_sel
      // EX is younger than WB, so its result wins when both hold the register
      assign op_sel[i] = ex_match_i[i] ? bypass_pkg::SEL_FW_EX :
                         wb_match_i[i] ? bypass_pkg::SEL_FW_WB :
                                         bypass_pkg::SEL_REGFILE;
    end
  endgenerate

  assign op_a_fw_sel_o = op_sel[0];
  assign op_b_fw_sel_o = op_sel[1];

  // A WB load result is not forwarded in practice because the JALR stall holds ID
  assign jalr_fw_sel_o = wb_jalr_match_i ? bypass_pkg::SELJ_FW_WB : bypass_pkg::SELJ_REGFILE;

  ////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////

  // Load data is not available in EX; in WB it is missing only while the bus has not answered
  assign load_stall_o = (ex_lsu_en_i && (|ex_match_i)) || (!wb_ready_i && (|wb_match_i));

  // The jump target path only takes ALU results from WB, anything in EX is too late
  assign jalr_stall_o = jalr_id_i && (ex_jalr_match_i || (wb_jalr_match_i && wb_lsu_en_i));

  // CSR and sleep stalls come straight from the CSR unit
  assign csr_stall_id_o = csr_stall_id_i;
  assign csr_stall_ex_o = csr_stall_ex_i;
  assign sleep_stall_o  = sleep_stall_i;

  // Summary per stage for the pipeline controller
  assign id_stall_o = load_stall_o || jalr_stall_o || csr_stall_id_i || sleep_stall_i;
  assign ex_stall_o = csr_stall_ex_i;

endmodule

`default_nettype wire

// ==== hw/csr_hazard_unit.sv ====
// Purely combinational; CSR read and write flags from EX and WB are expected to be raw and are gated here
`timescale 1ns/1ps
`default_nettype none

`include "bypass_macros.svh"

module csr_hazard_unit (
  // ID stage
  input  logic                  id_valid_i,
  input  logic                  id_mret_i,
  input  logic                  id_tbljmp_i,

  // EX stage
  input  logic                  ex_valid_i,
  input  logic                  ex_csr_en_i,
  input  logic                  ex_mret_i,
  input  logic                  ex_csr_impl_wr_i,
  input  logic                  ex_wfi_i,
  input  logic                  ex_csr_impl_re_i,
  input  logic                  ex_csr_expl_re_i,
  input  bypass_pkg::csr_addr_t ex_csr_raddr_i,

  // WB stage
  input  logic                  wb_valid_i,
  input  logic                  wb_csr_en_i,
  input  logic                  wb_mret_i,
  input  logic                  wb_csr_impl_wr_i,
  input  logic                  wb_csr_expl_we_i,
  input  bypass_pkg::csr_addr_t wb_csr_waddr_i,

  output logic                  csr_stall_id_o,
  output logic                  csr_stall_ex_o,
  output logic                  sleep_stall_o
);

  logic                       id_impl_rd;
  logic                       ex_impl_wr;
  logic                       wb_impl_wr;
  logic                       ex_any_wr;
  logic                       wb_any_wr;
  logic                       expl_hz_ex;
  logic [`BYP_CSR_ADDR_W-1:0] addr_diff;

  ////////////////////////////////////////////////////////////
  // Write detection
  ////////////////////////////////////////////////////////////

  // mret restores mstatus, and some CSR instructions update a second CSR as a side effect
  assign ex_impl_wr = ex_valid_i && (ex_mret_i || (ex_csr_en_i && ex_csr_impl_wr_i));
  assign wb_impl_wr = wb_valid_i && (wb_mret_i || (wb_csr_en_i && wb_csr_impl_wr_i));

  // Any CSR instruction counts as a writer, which keeps the ID check conservative
  assign ex_any_wr = (ex_valid_i && ex_csr_en_i) || ex_impl_wr;
  assign wb_any_wr = (wb_valid_i && wb_csr_en_i) || wb_impl_wr;

  ////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////

  // mret reads mepc in ID and a table jump reads jvt in ID
  assign id_impl_rd = id_valid_i && (id_mret_i || id_tbljmp_i);

  // ID waits until no CSR update is left ahead of it
  assign csr_stall_id_o = id_impl_rd && (ex_any_wr || wb_any_wr);

  // Zero bits mark an exact address hit between the EX read and the WB write
  assign addr_diff = ex_csr_raddr_i ^ wb_csr_waddr_i;

  // Only this case is precise, the others stall on any matching class of access
  assign expl_hz_ex = ex_valid_i && ex_csr_expl_re_i &&
                      wb_valid_i && wb_csr_expl_we_i && !(|addr_diff);

  // Implicit read in EX against any write in WB, explicit access against implicit write in WB
  assign csr_stall_ex_o = (ex_valid_i && ex_csr_impl_re_i && wb_any_wr) ||
                          (ex_valid_i && ex_csr_en_i && wb_impl_wr) ||
                          expl_hz_ex;

  // Keep loads and stores behind a WFI out of EX until the core has decided to sleep
  assign sleep_stall_o = ex_valid_i && ex_wfi_i;

endmodule

`default_nettype wire

// ==== hw/reg_hazard_unit.sv ====
// Purely combinational; match outputs are qualified with writer valid and write enable, x0 never matches
`timescale 1ns/1ps
`default_nettype none

`include "bypass_macros.svh"

module reg_hazard_unit (
  // Decoder read enables and read addresses in ID
  input  bypass_pkg::rd_port_vec_t rf_re_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_a_id_i,
  input  bypass_pkg::rf_addr_t     rf_raddr_b_id_i,

  // Writer in EX
  input  logic                     ex_valid_i,
  input  logic                     ex_rf_we_i,
  input  bypass_pkg::rf_addr_t     ex_rf_waddr_i,

  // Writer in WB
  input  logic                     wb_valid_i,
  input  logic                     wb_rf_we_i,
  input  bypass_pkg::rf_addr_t     wb_rf_waddr_i,

  // Per-port read-after-write matches
  output bypass_pkg::rd_port_vec_t ex_match_o,
  output bypass_pkg::rd_port_vec_t wb_match_o,

  // rs1 matches for the jump register path
  output logic                     ex_jalr_match_o,
  output logic                     wb_jalr_match_o
);

  // Read addresses gathered per port so the comparison can be generated
  bypass_pkg::rf_addr_t raddr [`BYP_NUM_RD_PORTS];

  // A stage only counts as a writer when it holds a valid instruction that writes
  logic ex_writes;
  logic wb_writes;

  // Port 0 reads something other than x0
  logic rs1_nonzero;

  assign raddr[0] = rf_raddr_a_id_i;
  assign raddr[1] = rf_raddr_b_id_i;

  assign ex_writes = ex_valid_i && ex_rf_we_i;
  assign wb_writes = wb_valid_i && wb_rf_we_i;

  ////////////////////////////////////////////////////////////
  // Operand read ports
  ////////////////////////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < `BYP_NUM_RD_PORTS; i++) begin : gen_port_match
      // Writes to x0 are dropped by the register file, so a read of x0 never waits
      logic port_active;

      assign port_active = rf_re_id_i[i] && (|raddr[i]);

      // EX holds the youngest result for this register
      assign ex_match_o[i] = port_active && ex_writes && (raddr[i] == ex_rf_waddr_i);

      // WB holds an older result, used only when EX does not also match
      assign wb_match_o[i] = port_active && wb_writes && (raddr[i] == wb_rf_waddr_i);
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Jump register path
  ////////////////////////////////////////////////////////////

  // The JALR base always comes from rs1 on port 0
  // A JALR always reads rs1, so the decoder read enable is implied and left out here
  assign rs1_nonzero = |rf_raddr_a_id_i;

  // The caller qualifies these with the JALR flag in ID
  assign ex_jalr_match_o = rs1_nonzero && ex_writes && (rf_raddr_a_id_i == ex_rf_waddr_i);
  assign wb_jalr_match_o = rs1_nonzero && wb_writes && (rf_raddr_a_id_i == wb_rf_waddr_i);

endmodule

`default_nettype wire

// ==== hw/bypass_pkg.sv ====
// Shared types for the bypass control; widths come from the macros header, selects are 2 and 1 bits
`default_nettype none

`include "bypass_macros.svh"

package bypass_pkg;

  ////////////////////////////////////////////////////////////
  // Address types
  ////////////////////////////////////////////////////////////

  // Register file index, x0 is the hardwired zero register
  typedef logic [`BYP_RF_ADDR_W-1:0] rf_addr_t;

  // CSR address
  typedef logic [`BYP_CSR_ADDR_W-1:0] csr_addr_t;

  // One flag per ID read port, bit 0 is operand a
  typedef logic [`BYP_NUM_RD_PORTS-1:0] rd_port_vec_t;

  ////////////////////////////////////////////////////////////
  // Forward mux selects
  ////////////////////////////////////////////////////////////

  // Operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_sel_e;

  // Jump target base for JALR, only WB can forward
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage

`default_nettype wire

// ==== hw/bypass_macros.svh ====
// Width constants only; the read-port count is fixed at two and must not be changed here
`ifndef BYPASS_MACROS_SVH
`define BYPASS_MACROS_SVH

////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////

// Integer register index width, 32 architectural registers
`define BYP_RF_ADDR_W 5

// Number of ID read ports (rs1 on port 0, rs2 on port 1)
`define BYP_NUM_RD_PORTS 2

////////////////////////////////////////////////////////////
// CSR space
////////////////////////////////////////////////////////////

// Full CSR address as encoded in the csr field of the instruction
`define BYP_CSR_ADDR_W 12

`endif
